//--- source/throttle_cfg.svh
// Packet throttle configuration: widths and limits shared by the throttle design
`ifndef THROTTLE_CFG_SVH
`define THROTTLE_CFG_SVH

// --------------------
// Stream payload
// --------------------

// Data bits carried in one beat
`define DATA_W 32

// Log2 of the longest packet in beats
`define MTU 4

// --------------------
// Rate control
// --------------------

// Throttle setting, whole.fraction
`define THROTTLE_W 8

// Fraction bits of throttle and credit
`define FRAC_W 4

// Credit must hold a full packet charged at the slowest rate
`define CREDIT_W (`THROTTLE_W + `MTU + 1)

`endif

//--- source/pkt_throttle_pkg.sv
// Packet throttle types: beat, throttle setting and fixed-point credit
package pkt_throttle_pkg;

  `include "throttle_cfg.svh"

  // --------------------
  // Stream beat
  // --------------------

  // One beat of the packet stream
  // Last marks the final beat of a packet
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic               last;
  } axis_beat_t;

  // --------------------
  // Rate control
  // --------------------

  // Throttle setting
  // Upper bits are whole cycles, lower FRAC_W bits are sixteenths
  // Allowed rate is one beat per (1 + throttle) cycles
  typedef logic [`THROTTLE_W-1:0] throttle_t;

  // Outstanding credit in cycles, unsigned fixed point
  // Lower FRAC_W bits are the fraction
  // Whole part nonzero means the output is ahead of the allowed rate
  typedef logic [`CREDIT_W-1:0] credit_t;

endpackage

//--- source/axis_skid_buffer.sv
// Skid buffer: two-entry register stage that breaks the ready path at full rate
`timescale 1ns/1ps

module axis_skid_buffer (
  input  logic                        clk,
  input  logic                        rst,
  // Upstream side
  input  pkt_throttle_pkg::axis_beat_t i_beat,
  input  logic                        i_valid,
  output logic                        o_ready,
  // Downstream side
  output pkt_throttle_pkg::axis_beat_t o_beat,
  output logic                        o_valid,
  input  logic                        i_ready
);

  import pkt_throttle_pkg::*;

  // --------------------
  // Storage
  // --------------------

  // Main register drives the output
  axis_beat_t main_beat;
  logic       main_valid;

  // Skid register catches the beat in flight when downstream stalls
  axis_beat_t skid_beat;
  logic       skid_valid;

  // Handshake events
  logic in_xfer;
  logic load_main;

  // Ready comes straight from a flop, no combinational path from i_ready
  assign o_ready = !skid_valid;

  assign in_xfer = i_valid && o_ready;

  // Main register can take a new beat when empty or being drained
  assign load_main = !main_valid || i_ready;

  // --------------------
  // Control state
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (load_main) begin
        // Skid entry is older, so it goes first
        if (skid_valid) begin
          main_valid <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          main_valid <= in_xfer;
        end
      end else if (in_xfer) begin
        // Output stalled, park the accepted beat
        // o_ready drops on the next cycle
        skid_valid <= 1'b1;
      end
    end
  end

  // --------------------
  // Payload
  // --------------------

  always_ff @(posedge clk) begin
    if (load_main) begin
      if (skid_valid) begin
        main_beat <= skid_beat;
      end else if (in_xfer) begin
        main_beat <= i_beat;
      end
    end else if (in_xfer) begin
      skid_beat <= i_beat;
    end
  end

  // Output side
  assign o_beat  = main_beat;
  assign o_valid = main_valid;

endmodule

//--- source/throttle_credit_acc.sv
// Credit accumulator: charges each output beat and repays one cycle per clock
`timescale 1ns/1ps

`include "throttle_cfg.svh"

module throttle_credit_acc (
  input  logic                       clk,
  input  logic                       rst,
  // Rate setting, whole.fraction cycles of extra spacing
  input  pkt_throttle_pkg::throttle_t i_throttle,
  // One pulse per output transfer
  input  logic                       i_xfer,
  // Outstanding credit
  output pkt_throttle_pkg::credit_t   o_credit,
  // Credit held at zero with repayment lost
  output logic                       o_underflow
);

  import pkt_throttle_pkg::*;

  // --------------------
  // Constants
  // --------------------

  // One whole cycle in credit units
  localparam credit_t ONE = credit_t'(1 << `FRAC_W);

  // Same value one bit wider, for the unsaturated sum
  localparam logic [`CREDIT_W:0] ONE_EXT = {1'b0, ONE};

  // --------------------
  // State
  // --------------------

  credit_t   credit_q;
  throttle_t throttle_q;
  logic      underflow_q;

  // Per-beat charge, 1 + throttle cycles
  credit_t charge;

  // Wide sum so nothing wraps before saturation
  logic [`CREDIT_W:0] sum;

  // Credit after repayment, valid once the sum covers one cycle
  credit_t diff;

  // Next state
  credit_t credit_d;
  logic    lost;

  // Charge from the registered setting
  // A new throttle shows up on the next beat, never the one in flight
  assign charge = ONE + credit_t'(throttle_q);

  // Add the charge only on a transfer
  assign sum = {1'b0, credit_q} + (i_xfer ? {1'b0, charge} : '0);

  assign diff = credit_t'(sum - ONE_EXT);

  // --------------------
  // Repayment and saturation
  // --------------------

  always_comb begin
    if (sum < ONE_EXT) begin
      // Idle time is not banked, clamp at zero and flag it
      credit_d = '0;
      lost     = 1'b1;
    end else begin
      credit_d = diff;
      lost     = 1'b0;
    end
  end

  // --------------------
  // Registers
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q    <= '0;
      throttle_q  <= '0;
      underflow_q <= 1'b0;
    end else begin
      credit_q    <= credit_d;
      // Sampled every clock, so the value seen at each transfer is
      // the setting from the cycle before
      throttle_q  <= i_throttle;
      underflow_q <= lost;
    end
  end

  // New credit is visible the cycle after the transfer
  assign o_credit    = credit_q;
  assign o_underflow = underflow_q;

endmodule

//--- source/pkt_gate_ctrl.sv
// Packet gate: holds the first beat of a packet while rate credit is outstanding
`timescale 1ns/1ps

`include "throttle_cfg.svh"

module pkt_gate_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  // From the skid buffer
  input  pkt_throttle_pkg::axis_beat_t i_beat,
  input  logic                        i_valid,
  output logic                        o_ready,
  // To the output port
  output pkt_throttle_pkg::axis_beat_t o_beat,
  output logic                        o_valid,
  input  logic                        i_ready,
  // Credit from the accumulator
  input  pkt_throttle_pkg::credit_t    i_credit,
  // Pulse per output transfer
  output logic                        o_xfer
);

  // --------------------
  // Start-of-packet tracking
  // --------------------

  // Set when the next beat opens a packet
  logic sop_q;

  // Whole cycles of credit still owed
  logic [`CREDIT_W-`FRAC_W-1:0] credit_whole;

  // Gate engaged
  logic block;

  // Output handshake completes
  logic xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      // First beat after reset opens a packet
      sop_q <= 1'b1;
    end else if (xfer) begin
      // Last beat ends the packet, anything else is mid-packet
      sop_q <= i_beat.last;
    end
  end

  // --------------------
  // Gate decision
  // --------------------

  // Fraction bits never hold a packet back
  assign credit_whole = i_credit[`CREDIT_W-1:`FRAC_W];

  // Only a first beat waits, and only while a whole cycle is owed
  // Mid-packet beats always pass
  assign block = sop_q && (credit_whole != '0);

  // --------------------
  // Handshake
  // --------------------

  // Both directions stall together while blocked
  // Upstream keeps its beat, downstream sees nothing valid
  assign o_valid = i_valid && !block;
  assign o_ready = i_ready && !block;

  // Beat itself is never altered
  assign o_beat = i_beat;

  assign xfer = o_valid && i_ready;

  // Accumulator charges one beat per pulse
  assign o_xfer = xfer;

endmodule

//--- source/axis_pkt_throttle.sv
// Packet rate throttle: skid buffer, start-of-packet gate and credit accumulator
`timescale 1ns/1ps

module axis_pkt_throttle (
  input  logic                        clk,
  input  logic                        rst,
  // Rate setting, one beat per (1 + throttle) cycles
  input  pkt_throttle_pkg::throttle_t  i_throttle,
  // Input stream
  input  pkt_throttle_pkg::axis_beat_t i_beat,
  input  logic                        i_valid,
  output logic                        o_ready,
  // Output stream
  output pkt_throttle_pkg::axis_beat_t o_beat,
  output logic                        o_valid,
  input  logic                        i_ready,
  // Status
  output logic                        o_underflow
);

  import pkt_throttle_pkg::*;

  // --------------------
  // Internal wiring
  // --------------------

  // Skid buffer to gate
  axis_beat_t buf_beat;
  logic       buf_valid;
  logic       buf_ready;

  // Gate to accumulator
  logic       out_xfer;

  // Accumulator to gate
  credit_t    credit;

  // --------------------
  // Input register stage
  // --------------------

  // One cycle of latency, full rate under back-pressure
  axis_skid_buffer skid_i (
    .clk     (clk),
    .rst     (rst),
    .i_beat  (i_beat),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_beat  (buf_beat),
    .o_valid (buf_valid),
    .i_ready (buf_ready)
  );

  // --------------------
  // Packet gate
  // --------------------

  // Holds new packets until credit drains below one cycle
  pkt_gate_ctrl gate_i (
    .clk      (clk),
    .rst      (rst),
    .i_beat   (buf_beat),
    .i_valid  (buf_valid),
    .o_ready  (buf_ready),
    .o_beat   (o_beat),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .i_credit (credit),
    .o_xfer   (out_xfer)
  );

  // --------------------
  // Rate accounting
  // --------------------

  throttle_credit_acc credit_i (
    .clk         (clk),
    .rst         (rst),
    .i_throttle  (i_throttle),
    .i_xfer      (out_xfer),
    .o_credit    (credit),
    .o_underflow (o_underflow)
  );

endmodule

//--- tb/axis_pkt_throttle_tb.sv
// Packet throttle testbench: random packets, stalling ends, reference queue and rate checks
`timescale 1ns/1ps

`include "throttle_cfg.svh"

module axis_pkt_throttle_tb;

  import pkt_throttle_pkg::*;

  // --------------------
  // Test sizes
  // --------------------

  // Packets per phase, in run order
  localparam int P1_PKTS = 6;
  localparam int P2_PKTS = 20;
  localparam int P3_PKTS = 12;
  localparam int P4_PKTS = 8;
  localparam int P5_PKTS = 4;
  localparam int BURST_PKTS = 4;
  localparam int P5_FIRST = P1_PKTS + P2_PKTS + P3_PKTS + P4_PKTS;
  localparam int N_PKTS = P5_FIRST + P5_PKTS + BURST_PKTS;

  // One whole cycle in sixteenths
  localparam int ONE = 1 << `FRAC_W;
  // Rate 0.1 means nine extra cycles per beat
  localparam int SLOW_THR = 9 * ONE;

  logic       clk;
  logic       rst;
  throttle_t  i_throttle;
  axis_beat_t i_beat;
  logic       i_valid;
  logic       o_ready;
  axis_beat_t o_beat;
  logic       o_valid;
  logic       i_ready;
  logic       o_underflow;

  // Stimulus and reference state
  axis_beat_t src_q[$];
  axis_beat_t exp_q[$];
  int         pkt_len[N_PKTS];
  int         pkt_idx;
  logic [31:0] rng_state;
  int         cur_thr;
  int         src_stall;
  int         snk_stall;

  // Handshakes seen just before the next edge
  logic       in_fire;
  logic       out_fire;
  axis_beat_t out_seen;
  int         cycle_cnt;

  // Packet spacing tracker
  logic       out_sop;
  logic       have_prev;
  logic       chk_max;
  int         prev_start;
  int         cur_len;
  int         done_len;

  // Underflow edge counters
  logic       uf_on;
  logic       uf_prev;
  int         uf_rise;
  int         uf_fall;

  // Full-rate burst tracker
  logic       burst_on;
  int         burst_cnt;
  int         burst_first;
  int         burst_last;

  int         err_cnt;
  int         check_cnt;
  int         wd_limit_ns;
  logic       wd_armed;

  axis_pkt_throttle dut_i (
    .clk         (clk),
    .rst         (rst),
    .i_throttle  (i_throttle),
    .i_beat      (i_beat),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .o_beat      (o_beat),
    .o_valid     (o_valid),
    .i_ready     (i_ready),
    .o_underflow (o_underflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Random numbers
  // --------------------

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper bits only, the low bits of an LCG cycle quickly
  function int rand_below(input int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  // --------------------
  // Output checking
  // --------------------

  task automatic check_output(input axis_beat_t got);
    axis_beat_t exp;
    int gap;
    int nominal;
    check_cnt++;
    if (exp_q.size() == 0) begin
      err_cnt++;
      $display("[ERROR] %0t ns: output beat %h with nothing expected", $time, got);
    end else begin
      exp = exp_q.pop_front();
      if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t ns: beat data %h last %b, expected data %h last %b",
                 $time, got.data, got.last, exp.data, exp.last);
      end
    end
    // Start-to-start spacing, charged at the previous packet's length
    if (out_sop) begin
      if (have_prev) begin
        gap = cycle_cnt - prev_start;
        nominal = (done_len * (ONE + cur_thr)) >> `FRAC_W;
        check_cnt++;
        if (gap < nominal - 1) begin
          err_cnt++;
          $display("[ERROR] %0t ns: packet spacing %0d below minimum %0d",
                   $time, gap, nominal - 1);
        end
        // Fraction left over from the packet before may cost one more cycle
        if (chk_max && gap > nominal + 1) begin
          err_cnt++;
          $display("[ERROR] %0t ns: packet spacing %0d above limit %0d",
                   $time, gap, nominal + 1);
        end
      end
      prev_start = cycle_cnt;
      have_prev  = 1'b1;
    end
    cur_len++;
    if (got.last) begin
      done_len = cur_len;
      cur_len  = 0;
    end
    out_sop = got.last;
    if (burst_on) begin
      if (burst_cnt == 0) burst_first = cycle_cnt;
      burst_cnt++;
      burst_last = cycle_cnt;
    end
  endtask

  // --------------------
  // Clock step
  // --------------------

  // Edge, then drive 1 ns later, then sample 1 ns after that
  task automatic tick();
    @(posedge clk);
    cycle_cnt++;
    if (in_fire) src_q.delete(0);
    if (out_fire) check_output(out_seen);
    #1;
    // A valid beat stays put until it is taken
    if (!(i_valid && !in_fire)) begin
      if (src_q.size() > 0 && rand_below(100) >= src_stall) begin
        i_valid = 1'b1;
        i_beat  = src_q[0];
      end else begin
        i_valid = 1'b0;
      end
    end
    i_ready    = (rand_below(100) >= snk_stall);
    i_throttle = throttle_t'(cur_thr);
    #1;
    in_fire  = i_valid && o_ready;
    out_fire = o_valid && i_ready;
    out_seen = o_beat;
    if (uf_on) begin
      if (o_underflow && !uf_prev) uf_rise++;
      if (!o_underflow && uf_prev) uf_fall++;
    end
    uf_prev = o_underflow;
  endtask

  task automatic send_packet(input int len);
    axis_beat_t b;
    for (int i = 0; i < len; i++) begin
      b.data = next_rand();
      b.last = (i == len - 1);
      src_q.push_back(b);
      exp_q.push_back(b);
    end
  endtask

  // Run until every beat is out and credit has settled at zero
  task automatic drain();
    while (src_q.size() > 0 || exp_q.size() > 0 || !uf_prev) tick();
  endtask

  task automatic run_group(input int thr, input int npk, input int s_in,
                           input int s_out, input logic strict);
    cur_thr   = thr;
    src_stall = s_in;
    snk_stall = s_out;
    chk_max   = strict;
    have_prev = 1'b0;
    repeat (4) tick();
    for (int i = 0; i < npk; i++) begin
      send_packet(pkt_len[pkt_idx]);
      pkt_idx++;
    end
    drain();
  endtask

  // --------------------
  // Watchdog
  // --------------------

  initial begin
    wait (wd_armed);
    #(wd_limit_ns);
    $display("Watchdog expired: run did not finish within %0d ns", wd_limit_ns);
    $display("Test failures found");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int total;
    int burst_beats;
    rst = 1'b1;
    i_throttle = '0;
    i_beat = '0;
    i_valid = 1'b0;
    i_ready = 1'b0;
    rng_state = 32'h2427;
    cur_thr = 0;
    src_stall = 0;
    snk_stall = 0;
    in_fire = 1'b0;
    out_fire = 1'b0;
    out_seen = '0;
    cycle_cnt = 0;
    out_sop = 1'b1;
    have_prev = 1'b0;
    chk_max = 1'b0;
    prev_start = 0;
    cur_len = 0;
    done_len = 0;
    uf_on = 1'b0;
    uf_prev = 1'b0;
    uf_rise = 0;
    uf_fall = 0;
    burst_on = 1'b0;
    burst_cnt = 0;
    burst_first = 0;
    burst_last = 0;
    err_cnt = 0;
    check_cnt = 0;
    pkt_idx = 0;
    wd_armed = 1'b0;

    // All packet lengths up front, so the watchdog knows the beat total
    total = 0;
    for (int i = 0; i < N_PKTS; i++) begin
      if (i >= P5_FIRST && i < P5_FIRST + P5_PKTS) pkt_len[i] = 6 + rand_below(5);
      else pkt_len[i] = 1 + rand_below(16);
      total += pkt_len[i];
    end
    wd_limit_ns = total * 17 * 4 + 2000;
    wd_armed = 1'b1;

    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    #1;
    check_cnt++;
    if (o_valid !== 1'b0 || o_underflow !== 1'b0 || o_ready !== 1'b1) begin
      err_cnt++;
      $display("[ERROR] %0t ns: after reset valid %b underflow %b ready %b",
               $time, o_valid, o_underflow, o_ready);
    end

    // Full rate, no stalls
    run_group(0, P1_PKTS, 0, 0, 1'b1);
    // Random stalls on both sides, several rates
    repeat (4) run_group(rand_below(SLOW_THR + 1), P2_PKTS / 4, 30, 30, 1'b0);
    // Stall free, spacing held to a narrow window
    repeat (3) run_group(rand_below(SLOW_THR + 1), P3_PKTS / 3, 0, 0, 1'b1);
    // Heavy stalls, minimum spacing only
    repeat (2) run_group(rand_below(SLOW_THR + 1), P4_PKTS / 2, 70, 80, 1'b0);

    // Sparse packets at rate 0.1, each followed by an idle gap
    cur_thr = SLOW_THR;
    src_stall = 0;
    snk_stall = 0;
    chk_max = 1'b0;
    have_prev = 1'b0;
    repeat (4) tick();
    uf_on = 1'b1;
    for (int i = 0; i < P5_PKTS; i++) begin
      send_packet(pkt_len[pkt_idx]);
      pkt_idx++;
      drain();
      repeat (40) tick();
    end
    uf_on = 1'b0;
    check_cnt++;
    if (uf_rise != uf_fall || uf_rise < P5_PKTS) begin
      err_cnt++;
      $display("[ERROR] %0t ns: underflow rises %0d falls %0d over %0d gaps",
               $time, uf_rise, uf_fall, P5_PKTS);
    end

    // Burst at throttle zero must leave one beat per cycle
    cur_thr = 0;
    have_prev = 1'b0;
    repeat (4) tick();
    burst_beats = 0;
    burst_on = 1'b1;
    for (int i = 0; i < BURST_PKTS; i++) begin
      burst_beats += pkt_len[pkt_idx];
      send_packet(pkt_len[pkt_idx]);
      pkt_idx++;
    end
    drain();
    burst_on = 1'b0;
    check_cnt++;
    if (burst_cnt != burst_beats || burst_last - burst_first + 1 != burst_cnt) begin
      err_cnt++;
      $display("[ERROR] %0t ns: burst of %0d beats took %0d cycles, %0d beats seen",
               $time, burst_beats, burst_last - burst_first + 1, burst_cnt);
    end

    $display("Checks: %0d, errors: %0d, packets: %0d, beats: %0d",
             check_cnt, err_cnt, pkt_idx, total);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+source
source/pkt_throttle_pkg.sv
source/axis_skid_buffer.sv
source/throttle_credit_acc.sv
source/pkt_gate_ctrl.sv
source/axis_pkt_throttle.sv
tb/axis_pkt_throttle_tb.sv
